//--- common/prf_cfg_pkg.sv
`default_nettype none

package prf_cfg_pkg;

   // ==============================
   // Register file sizing
   // ==============================
   localparam int PREGS     = 64;                 // Physical registers
   localparam int ARCH_REGS = 32;                 // Architectural registers, mapped at reset
   localparam int WID       = 64;                 // Register value width

   // ==============================
   // Derived sizes
   // ==============================
   // Tags below ARCH_REGS hold the initial architectural state,
   // everything above starts out free
   localparam int FREE_INIT = PREGS - ARCH_REGS;  // Initial free count and credit count
   localparam int TAG_W     = $clog2(PREGS);      // Physical tag width

endpackage

`default_nettype wire

//--- common/prf_types_pkg.sv
`default_nettype none

package prf_types_pkg;

   // ==============================
   // Scalar types
   // ==============================
   typedef logic [prf_cfg_pkg::TAG_W-1:0] preg_t;   // Physical register tag
   typedef logic [prf_cfg_pkg::WID-1:0]   value_t;  // Register value

   // Write port that last wrote a register
   typedef enum logic {
      BANK0 = 1'b0,
      BANK1 = 1'b1
   } bank_e;

   // ==============================
   // Port bundles
   // ==============================
   typedef struct packed {
      logic   valid;   // Write this cycle
      preg_t  tag;     // Destination register
      value_t data;    // Value to store
   } wr_req_t;

   typedef struct packed {
      logic  valid;    // Request this cycle
      preg_t tag;      // Register to read or release
   } rd_req_t;

   typedef struct packed {
      logic   valid;   // One cycle after the request
      value_t data;
   } rd_rsp_t;

   // Tag handed to rename
   typedef struct packed {
      logic  valid;
      preg_t tag;
   } alloc_rsp_t;

endpackage

`default_nettype wire

//--- regfile/regfile_ram.sv
`timescale 1ns/1ns
`default_nettype none

module regfile_ram (
   input  logic                  clka,
   input  logic                  ena,     // Write port enable
   input  logic                  wea,     // Write strobe
   input  prf_types_pkg::preg_t  addra,
   input  prf_types_pkg::value_t dina,
   input  logic                  enb,     // Read port enable
   input  prf_types_pkg::preg_t  addrb,
   output prf_types_pkg::value_t doutb
);

   // ==============================
   // Storage
   // ==============================
   (* ram_style = "distributed" *)
   prf_types_pkg::value_t mem [prf_cfg_pkg::PREGS];   // One word per physical register
   prf_types_pkg::preg_t  raddr_q;                    // Read address held for the lookup

   // Zero contents so early reads are defined in simulation
   initial begin
      for (int n = 0; n < prf_cfg_pkg::PREGS; n++) begin
         mem[n] = '0;
      end
   end

   always @(posedge clka) begin
      if (ena && wea) mem[addra] <= dina;         // Write port A
   end

   // Address captured at the same edge as the write
   always_ff @(posedge clka) begin
      if (enb) raddr_q <= addrb;
   end

   // Lookup after the write has landed gives write-first data
   assign doutb = mem[raddr_q];

endmodule

`default_nettype wire

//--- regfile/regfile_lvt.sv
`timescale 1ns/1ns
`default_nettype none

module regfile_lvt (
   input  logic                   clka,
   input  logic                   arst_n,
   input  prf_types_pkg::wr_req_t wr0,      // Bank 0 writer
   input  prf_types_pkg::wr_req_t wr1,      // Bank 1 writer
   input  prf_types_pkg::preg_t   raddr0,
   input  prf_types_pkg::preg_t   raddr1,
   output prf_types_pkg::bank_e   sel0,     // Bank holding the newest value for read 0
   output prf_types_pkg::bank_e   sel1
);

   // ==============================
   // Live value table
   // ==============================
   prf_types_pkg::bank_e lvt [prf_cfg_pkg::PREGS];   // Last writer per register
   prf_types_pkg::preg_t raddr0_q;                   // Aligned with RAM read address
   prf_types_pkg::preg_t raddr1_q;

   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < prf_cfg_pkg::PREGS; i++) begin
            lvt[i] <= prf_types_pkg::BANK0;    // Everything starts in bank 0
         end
      end else begin
         if (wr0.valid) lvt[wr0.tag] <= prf_types_pkg::BANK0;
         // Later assignment, so port 1 wins a same-tag collision
         if (wr1.valid) lvt[wr1.tag] <= prf_types_pkg::BANK1;
      end
   end

   // Addresses follow the RAMs by one cycle
   always_ff @(posedge clka) begin
      raddr0_q <= raddr0;
      raddr1_q <= raddr1;
   end

   // Table already holds this edge's update, so selection is write-first
   assign sel0 = lvt[raddr0_q];
   assign sel1 = lvt[raddr1_q];

endmodule

`default_nettype wire

//--- regfile/regfile_2w2r.sv
`timescale 1ns/1ns
`default_nettype none

module regfile_2w2r (
   input  logic                   clka,
   input  logic                   arst_n,
   input  prf_types_pkg::wr_req_t wr0,
   input  prf_types_pkg::wr_req_t wr1,
   input  prf_types_pkg::rd_req_t rd0,
   input  prf_types_pkg::rd_req_t rd1,
   output prf_types_pkg::rd_rsp_t rsp0,
   output prf_types_pkg::rd_rsp_t rsp1
);

   // ==============================
   // Bank outputs
   // ==============================
   prf_types_pkg::value_t b0_r0_data;   // Bank 0 copy seen by read 0
   prf_types_pkg::value_t b0_r1_data;
   prf_types_pkg::value_t b1_r0_data;   // Bank 1 copy seen by read 0
   prf_types_pkg::value_t b1_r1_data;
   prf_types_pkg::bank_e  sel0;         // Winning bank per read port
   prf_types_pkg::bank_e  sel1;
   logic [1:0]            rd_vld_q;     // Request valids delayed one cycle

   // Bank 0 written by port 0, one copy per reader
   regfile_ram u_ram_b0_r0 (
      .clka (clka),
      .ena  (wr0.valid),
      .wea  (1'b1),
      .addra(wr0.tag),
      .dina (wr0.data),
      .enb  (rd0.valid),
      .addrb(rd0.tag),
      .doutb(b0_r0_data)
   );

   regfile_ram u_ram_b0_r1 (
      .clka (clka),
      .ena  (wr0.valid),
      .wea  (1'b1),
      .addra(wr0.tag),
      .dina (wr0.data),
      .enb  (rd1.valid),
      .addrb(rd1.tag),
      .doutb(b0_r1_data)
   );

   // Bank 1 written by port 1
   regfile_ram u_ram_b1_r0 (
      .clka (clka),
      .ena  (wr1.valid),
      .wea  (1'b1),
      .addra(wr1.tag),
      .dina (wr1.data),
      .enb  (rd0.valid),
      .addrb(rd0.tag),
      .doutb(b1_r0_data)
   );

   regfile_ram u_ram_b1_r1 (
      .clka (clka),
      .ena  (wr1.valid),
      .wea  (1'b1),
      .addra(wr1.tag),
      .dina (wr1.data),
      .enb  (rd1.valid),
      .addrb(rd1.tag),
      .doutb(b1_r1_data)
   );

   regfile_lvt u_lvt (
      .clka  (clka),
      .arst_n(arst_n),
      .wr0   (wr0),
      .wr1   (wr1),
      .raddr0(rd0.tag),
      .raddr1(rd1.tag),
      .sel0  (sel0),
      .sel1  (sel1)
   );

   // ==============================
   // Response
   // ==============================
   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) rd_vld_q <= 2'b00;
      else         rd_vld_q <= {rd1.valid, rd0.valid};
   end

   assign rsp0.valid = rd_vld_q[0];
   assign rsp0.data  = (sel0 == prf_types_pkg::BANK1) ? b1_r0_data : b0_r0_data;
   assign rsp1.valid = rd_vld_q[1];
   assign rsp1.data  = (sel1 == prf_types_pkg::BANK1) ? b1_r1_data : b0_r1_data;

endmodule

`default_nettype wire

//--- rtl/free_list.sv
`timescale 1ns/1ns
`default_nettype none

module free_list (
   input  logic                      clka,
   input  logic                      arst_n,
   input  logic                      alloc_req,    // Rename wants a tag, one credit spent
   input  prf_types_pkg::rd_req_t    rel,          // Tag coming back from commit
   output prf_types_pkg::alloc_rsp_t alloc_rsp,
   output logic                      credit_ret    // One pulse per accepted release
);

   // ==============================
   // FIFO state
   // ==============================
   prf_types_pkg::preg_t          fifo [prf_cfg_pkg::PREGS];  // Free tag ring
   prf_types_pkg::preg_t          rd_ptr;                     // Head, next tag out
   prf_types_pkg::preg_t          wr_ptr;                     // Tail, next free slot
   logic [prf_cfg_pkg::TAG_W:0]   count;                      // Tags currently free
   logic                          pop;
   logic                          push;

   // Credits keep the list non-empty on a request
   assign pop  = alloc_req && (count != '0);
   assign push = rel.valid;

   // Head is presented in the same cycle as the request
   assign alloc_rsp.valid = pop;
   assign alloc_rsp.tag   = fifo[rd_ptr];

   // ==============================
   // Storage and pointers
   // ==============================
   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) begin
         // Slots 0 .. FREE_INIT-1 hold ARCH_REGS .. PREGS-1, the rest wrap
         for (int i = 0; i < prf_cfg_pkg::PREGS; i++) begin
            fifo[i] <= prf_types_pkg::preg_t'(prf_cfg_pkg::ARCH_REGS + i);
         end
      end else if (push) begin
         fifo[wr_ptr] <= rel.tag;               // Append released tag
      end
   end

   // Pointers wrap naturally, PREGS is a power of two
   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) begin
         rd_ptr <= '0;
         wr_ptr <= prf_types_pkg::preg_t'(prf_cfg_pkg::FREE_INIT);
      end else begin
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         if (push) wr_ptr <= wr_ptr + 1'b1;
      end
   end

   // Occupancy, push and pop together leave it unchanged
   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) begin
         count <= (prf_cfg_pkg::TAG_W + 1)'(prf_cfg_pkg::FREE_INIT);
      end else begin
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // ==============================
   // Credit return
   // ==============================
   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) credit_ret <= 1'b0;
      else         credit_ret <= rel.valid;   // One cycle after the release
   end

endmodule

`default_nettype wire

//--- rtl/prf_top.sv
`timescale 1ns/1ns
`default_nettype none

module prf_top (
   input  logic                      clka,
   input  logic                      arst_n,
   // Allocation to rename
   input  logic                      alloc_req,
   output prf_types_pkg::alloc_rsp_t alloc_rsp,
   // Release from commit
   input  prf_types_pkg::rd_req_t    rel,
   output logic                      credit_ret,
   // Register file ports
   input  prf_types_pkg::wr_req_t    wr  [2],
   input  prf_types_pkg::rd_req_t    rd  [2],
   output prf_types_pkg::rd_rsp_t    rsp [2]
);

   // ==============================
   // Tag management
   // ==============================
   free_list u_free_list (
      .clka      (clka),
      .arst_n    (arst_n),
      .alloc_req (alloc_req),
      .rel       (rel),
      .alloc_rsp (alloc_rsp),
      .credit_ret(credit_ret)
   );

   // ==============================
   // Register storage
   // ==============================
   regfile_2w2r u_regfile (
      .clka  (clka),
      .arst_n(arst_n),
      .wr0   (wr[0]),       // Bank 0 writer
      .wr1   (wr[1]),       // Bank 1 writer, wins collisions
      .rd0   (rd[0]),
      .rd1   (rd[1]),
      .rsp0  (rsp[0]),
      .rsp1  (rsp[1])
   );

endmodule

`default_nettype wire

//--- test/prf_checker.sv
`timescale 1ns/1ns
`default_nettype none

module prf_checker (
   input logic       clka,
   input logic       arst_n,
   input logic       alloc_req,
   input logic       alloc_vld,    // alloc_rsp.valid
   input logic       rel_vld,      // rel.valid
   input logic       credit_ret,
   input logic [1:0] rd_vld,       // Read request valids, port 1 in the upper bit
   input logic [1:0] rsp_vld
);

   // ==============================
   // Credit protocol
   // ==============================
   a_credit_follows_rel: assert property (
      @(posedge clka) disable iff (!arst_n) credit_ret == $past(rel_vld)
   ) else $error("credit_ret is not a one-cycle delayed copy of rel.valid");

   // Credits keep the list stocked, so every request is served
   a_req_served: assert property (
      @(posedge clka) disable iff (!arst_n) alloc_req |-> alloc_vld
   ) else $error("alloc_req not served, free list empty");

   // ==============================
   // Reset and read port timing
   // ==============================
   a_quiet_after_reset: assert property (
      @(posedge clka) $rose(arst_n) |-> !alloc_vld && !credit_ret && rsp_vld == 2'b00
   ) else $error("outputs active right after reset");

   // Response lags request by exactly one edge
   a_rsp_follows_rd: assert property (
      @(posedge clka) disable iff (!arst_n) rsp_vld == $past(rd_vld)
   ) else $error("rsp.valid does not follow rd.valid by one cycle");

endmodule

`default_nettype wire

//--- test/tb_prf.sv
`timescale 1ns/1ns
`default_nettype none

module tb_prf;

   logic                      clka   = 1'b0;
   logic                      arst_n = 1'b0;    // In reset from time zero
   logic                      alloc_req;
   prf_types_pkg::alloc_rsp_t alloc_rsp;
   prf_types_pkg::rd_req_t    rel;
   logic                      credit_ret;
   prf_types_pkg::wr_req_t    wr  [2];
   prf_types_pkg::rd_req_t    rd  [2];
   prf_types_pkg::rd_rsp_t    rsp [2];

   // ==============================
   // Reference model state
   // ==============================
   prf_types_pkg::value_t shadow [prf_cfg_pkg::PREGS];   // Newest value per register
   prf_types_pkg::preg_t  model_fifo [$];                // Free tags in hand-out order
   prf_types_pkg::preg_t  held [$];                      // Allocated, not yet released
   int                    credits;                       // Consumer side credit counter
   logic                  rel_prev;                      // Release seen last cycle
   logic [1:0]            pend;                          // Reads awaiting a response
   prf_types_pkg::value_t pend_data [2];
   int                    tag_errs, value_errs, credit_errs, valid_errs;

   initial forever #4 clka = ~clka;                      // 8 ns period

   prf_top DUT (
      .clka      (clka),
      .arst_n    (arst_n),
      .alloc_req (alloc_req),
      .alloc_rsp (alloc_rsp),
      .rel       (rel),
      .credit_ret(credit_ret),
      .wr        (wr),
      .rd        (rd),
      .rsp       (rsp)
   );

   bind prf_top prf_checker u_checker (
      .clka      (clka),
      .arst_n    (arst_n),
      .alloc_req (alloc_req),
      .alloc_vld (alloc_rsp.valid),
      .rel_vld   (rel.valid),
      .credit_ret(credit_ret),
      .rd_vld    ({rd[1].valid, rd[0].valid}),
      .rsp_vld   ({rsp[1].valid, rsp[0].valid})
   );

   // Head of the free list as rename should see it
   function automatic prf_types_pkg::preg_t expected_tag();
      return model_fifo[0];
   endfunction

   function automatic prf_types_pkg::value_t expected_read(input prf_types_pkg::preg_t t);
      return shadow[t];
   endfunction

   function automatic prf_types_pkg::rd_req_t make_rd(input prf_types_pkg::preg_t t);
      return {1'b1, t};
   endfunction

   function automatic prf_types_pkg::wr_req_t make_wr(input prf_types_pkg::preg_t t);
      return {1'b1, t, $urandom, $urandom};         // Random 64-bit payload
   endfunction

   function automatic prf_types_pkg::preg_t rand_tag();
      return prf_types_pkg::preg_t'($urandom_range(prf_cfg_pkg::PREGS - 1));
   endfunction

   // ==============================
   // Compare tasks
   // ==============================
   task automatic check_tag(input prf_types_pkg::preg_t got, input prf_types_pkg::preg_t exp,
                            input string what);
      if (got !== exp) begin
         tag_errs++;
         $display("[FAIL] %0t ns %s: tag %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_value(input prf_types_pkg::value_t got,
                              input prf_types_pkg::value_t exp, input string what);
      if (got !== exp) begin
         value_errs++;
         $display("[FAIL] %0t ns %s: data %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_credit(input int got, input int exp, input string what);
      if (got != exp) begin
         credit_errs++;
         $display("[FAIL] %0t ns %s: %0d credits, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_valid(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         valid_errs++;
         $display("[FAIL] %0t ns %s: valid %b, expected %b", $time, what, got, exp);
      end
   endtask

   // One cycle of stimulus, applied just after the rising edge
   task automatic drive(input logic a_req, input prf_types_pkg::rd_req_t r,
                        input prf_types_pkg::wr_req_t w0, input prf_types_pkg::wr_req_t w1,
                        input prf_types_pkg::rd_req_t q0, input prf_types_pkg::rd_req_t q1);
      @(posedge clka);
      alloc_req <= a_req;
      rel       <= r;
      wr[0]     <= w0;
      wr[1]     <= w1;
      rd[0]     <= q0;
      rd[1]     <= q1;
      if (a_req) credits--;                         // Spent on request
   endtask

   // Idle until reads and credit returns drain, then all released credits must be back
   task automatic wait_settled(input string what);
      int n;
      n = 0;
      drive(1'b0, '0, '0, '0, '0, '0);
      while ((pend != 2'b00 || rel_prev) && n < 50) begin
         drive(1'b0, '0, '0, '0, '0, '0);
         n++;
      end
      if (n >= 50) begin
         $display("Timed out waiting for read responses and credit returns after %s", what);
         $display("Test failures found");
         $finish;
      end
      check_credit(credits, model_fifo.size(), what);
   endtask

   // ==============================
   // Compare process, samples at the falling edge
   // ==============================
   always @(negedge clka) begin
      prf_types_pkg::preg_t exp_tag;
      if (!arst_n) begin
         check_valid(alloc_rsp.valid, 1'b0, "alloc_rsp in reset");
         check_valid(credit_ret, 1'b0, "credit_ret in reset");
         check_valid(rsp[0].valid, 1'b0, "rsp0 in reset");
         check_valid(rsp[1].valid, 1'b0, "rsp1 in reset");
         rel_prev = 1'b0;
         pend     = 2'b00;
      end else begin
         check_valid(alloc_rsp.valid, alloc_req, "alloc_rsp");
         if (alloc_req && model_fifo.size() == 0) begin
            valid_errs++;
            $display("Allocation requested while the model free list is empty");
         end else if (alloc_req) begin
            exp_tag = expected_tag();
            check_tag(alloc_rsp.tag, exp_tag, "alloc_rsp");
            held.push_back(exp_tag);
            model_fifo.delete(0);
         end
         check_valid(credit_ret, rel_prev, "credit_ret");
         if (credit_ret) credits++;                 // Pulse hands a credit back
         if (rel.valid) model_fifo.push_back(rel.tag);
         rel_prev = rel.valid;
         for (int j = 0; j < 2; j++) begin
            check_valid(rsp[j].valid, pend[j], $sformatf("rsp%0d", j));
            if (pend[j]) check_value(rsp[j].data, pend_data[j], $sformatf("rsp%0d", j));
         end
         // Port 1 applied last so it wins a same-tag write
         if (wr[0].valid) shadow[wr[0].tag] = wr[0].data;
         if (wr[1].valid) shadow[wr[1].tag] = wr[1].data;
         for (int j = 0; j < 2; j++) begin
            pend[j] = rd[j].valid;
            if (rd[j].valid) pend_data[j] = expected_read(rd[j].tag);  // Write-first
         end
      end
   end

   // ==============================
   // Stimulus
   // ==============================
   initial begin
      prf_types_pkg::rd_req_t r;
      prf_types_pkg::wr_req_t w;
      prf_types_pkg::preg_t   t;
      logic                   a;
      int                     k;
      void'($urandom(32'ha08c_6f6b));
      alloc_req = 1'b0;
      rel       = '0;
      wr[0]     = '0;
      wr[1]     = '0;
      rd[0]     = '0;
      rd[1]     = '0;
      for (int i = 0; i < prf_cfg_pkg::PREGS; i++) shadow[i] = '0;
      for (int i = 0; i < prf_cfg_pkg::FREE_INIT; i++) begin
         model_fifo.push_back(prf_types_pkg::preg_t'(prf_cfg_pkg::ARCH_REGS + i));
      end
      credits = prf_cfg_pkg::FREE_INIT;
      repeat (10) @(posedge clka);
      arst_n <= 1'b1;

      // Drain the initial free tags, 32 up to 63
      for (int i = 0; i < prf_cfg_pkg::FREE_INIT; i++) drive(1'b1, '0, '0, '0, '0, '0);
      wait_settled("initial allocation");

      // Releases and allocations mixed, never beyond the credits held
      for (int i = 0; i < 300; i++) begin
         r = '0;
         if (held.size() != 0 && $urandom_range(1) == 1) begin
            k = $urandom_range(held.size() - 1);
            r = make_rd(held[k]);
            held.delete(k);
         end
         a = (credits > 0) && ($urandom_range(1) == 1);
         drive(a, r, '0, '0, '0, '0);
      end
      wait_settled("credit traffic");

      for (int i = 0; i < 64; i++) begin
         drive(1'b0, '0, make_wr(rand_tag()), make_wr(rand_tag()), '0, '0);
      end
      for (int i = 0; i < 64; i++) begin
         drive(1'b0, '0, '0, '0, make_rd(rand_tag()), make_rd(rand_tag()));
      end
      wait_settled("random writes then reads");

      // Read in the write cycle, alternating the writing port
      for (int i = 0; i < 16; i++) begin
         t = rand_tag();
         w = make_wr(t);
         if (i % 2 == 1) drive(1'b0, '0, '0, w, make_rd(t), make_rd(t));
         else            drive(1'b0, '0, w, '0, make_rd(t), make_rd(t));
      end
      wait_settled("write-first reads");

      // Both ports on one tag, read back next cycle
      for (int i = 0; i < 8; i++) begin
         t = rand_tag();
         drive(1'b0, '0, make_wr(t), make_wr(t), '0, '0);
         drive(1'b0, '0, '0, '0, make_rd(t), make_rd(t));
      end
      wait_settled("same-tag collisions");

      $display("Errors: tag %0d, value %0d, credit %0d, valid %0d",
               tag_errs, value_errs, credit_errs, valid_errs);
      if (tag_errs + value_errs + credit_errs + valid_errs == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
common/prf_cfg_pkg.sv
common/prf_types_pkg.sv
regfile/regfile_ram.sv
regfile/regfile_lvt.sv
regfile/regfile_2w2r.sv
rtl/free_list.sv
rtl/prf_top.sv
test/prf_checker.sv
test/tb_prf.sv

//--- Makefile
# Verilator build and run of the physical register file testbench

LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_prf \
		-f filelist.f -o Vtb_prf

run: build
	./obj_dir/Vtb_prf > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failures found" $(LOG); then exit 1; fi

lint:
	verilator --lint-only --timing -Wall --top-module tb_prf -f filelist.f

clean:
	rm -rf obj_dir $(LOG)
